//--- Makefile
# Verilator build and run of the memory stage testbench

TOP := mem_stage_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

//--- logic/load_aligner.sv
`timescale 1ns/1ps

module load_aligner
    import mem_stage_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  mem_op_e     op,
    input  logic [31:0] rdata,
    input  logic        rdata_valid,
    input  logic        amo_write,
    output logic [31:0] load_data
);

    logic [31:0] ext_data;
    logic [31:0] old_word;

    // sign or zero extension by load kind
    always_comb begin
        case (op)
            mem_lb:  ext_data = {{24{rdata[7]}}, rdata[7:0]};
            mem_lbu: ext_data = {24'h0, rdata[7:0]};
            mem_lh:  ext_data = {{16{rdata[15]}}, rdata[15:0]};
            mem_lhu: ext_data = {16'h0, rdata[15:0]};
            default: ext_data = rdata;
        endcase
    end

    // old value of a swap, needed after its write half
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            old_word <= '0;
        end else if (rdata_valid && op == mem_amoswap) begin
            old_word <= rdata;
        end
    end

    assign load_data = amo_write ? old_word : ext_data;

endmodule

//--- logic/mem_access_ctrl.sv
`timescale 1ns/1ps

module mem_access_ctrl
    import mem_stage_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush,
    input  mem_op_e cur_op,
    input  mem_op_e saved_op,
    input  logic    cmd_ready,
    input  logic    rdata_valid,
    output logic    capture,
    output logic    use_saved,
    output logic    amo_write,
    output logic    cmd_start,
    output logic    cmd_write,
    output logic    retire_current,
    output logic    retire_saved,
    output logic    stall
);

    typedef enum logic [1:0] {
        st_idle        = 2'd0,
        st_wait_ready  = 2'd1,
        st_wait_rvalid = 2'd2,
        st_amo_write   = 2'd3
    } state_e;

    state_e state;
    state_e state_next;

    function automatic logic is_store_op(input mem_op_e op);
        return op inside {mem_sb, mem_sh, mem_sw};
    endfunction

    // the swap starts out as a read
    function automatic logic is_read_op(input mem_op_e op);
        return op inside {mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu, mem_amoswap};
    endfunction

    // ************************************************************
    // next state and strobes
    // ************************************************************
    always_comb begin
        state_next     = state;
        capture        = 1'b0;
        use_saved      = 1'b0;
        amo_write      = 1'b0;
        cmd_start      = 1'b0;
        cmd_write      = 1'b0;
        retire_current = 1'b0;
        retire_saved   = 1'b0;
        stall          = 1'b0;

        if (flush) begin
            // drop whatever is in flight, no more commands
            state_next = st_idle;
        end else begin
            case (state)
                st_idle: begin
                    capture = 1'b1;
                    if (is_store_op(cur_op)) begin
                        cmd_start = 1'b1;
                        cmd_write = 1'b1;
                        if (cmd_ready) begin
                            retire_current = 1'b1;
                        end else begin
                            stall      = 1'b1;
                            state_next = st_wait_ready;
                        end
                    end else if (is_read_op(cur_op)) begin
                        cmd_start  = 1'b1;
                        stall      = 1'b1;
                        state_next = cmd_ready ? st_wait_rvalid : st_wait_ready;
                    end else begin
                        retire_current = 1'b1;
                    end
                end
                st_wait_ready: begin
                    // keep the command up until memory takes it
                    use_saved = 1'b1;
                    cmd_start = 1'b1;
                    cmd_write = is_store_op(saved_op);
                    stall     = 1'b1;
                    if (cmd_ready) begin
                        if (is_store_op(saved_op)) begin
                            retire_saved = 1'b1;
                            stall        = 1'b0;
                            state_next   = st_idle;
                        end else begin
                            state_next = st_wait_rvalid;
                        end
                    end
                end
                st_wait_rvalid: begin
                    use_saved = 1'b1;
                    stall     = 1'b1;
                    if (rdata_valid) begin
                        if (saved_op == mem_amoswap) begin
                            state_next = st_amo_write;
                        end else begin
                            retire_saved = 1'b1;
                            stall        = 1'b0;
                            state_next   = st_idle;
                        end
                    end
                end
                st_amo_write: begin
                    // write half of the swap
                    use_saved = 1'b1;
                    amo_write = 1'b1;
                    cmd_start = 1'b1;
                    cmd_write = 1'b1;
                    stall     = 1'b1;
                    if (cmd_ready) begin
                        retire_saved = 1'b1;
                        stall        = 1'b0;
                        state_next   = st_idle;
                    end
                end
                default: begin
                    state_next = st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

//--- logic/mem_stage_pkg.sv
package mem_stage_pkg;

    // ************************************************************
    // operation codes
    // ************************************************************

    // memory operation carried with each instruction
    typedef enum logic [3:0] {
        mem_none    = 4'd0,
        mem_lb      = 4'd1,
        mem_lh      = 4'd2,
        mem_lw      = 4'd3,
        mem_lbu     = 4'd4,
        mem_lhu     = 4'd5,
        mem_sb      = 4'd6,
        mem_sh      = 4'd7,
        mem_sw      = 4'd8,
        mem_amoswap = 4'd9
    } mem_op_e;

    // write-back source select
    typedef enum logic [1:0] {
        wb_alu  = 2'd0,
        wb_mem  = 2'd1,
        wb_pc4  = 2'd2,
        wb_none = 2'd3
    } wb_sel_e;

    // ************************************************************
    // stage bundles
    // ************************************************************

    // execute to memory
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] alu_out;
        logic [31:0] rs2_data;
        logic        br_flg;
        logic [31:0] br_target;
        logic        jmp_flg;
        mem_op_e     mem_op;
        logic        rf_wen;
        wb_sel_e     wb_sel;
        logic [4:0]  wb_addr;
    } stage_in_t;

    // memory to write-back
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] alu_out;
        logic [31:0] read_data;
        logic        br_flg;
        logic [31:0] br_target;
        logic        jmp_flg;
        logic        rf_wen;
        wb_sel_e     wb_sel;
        logic [4:0]  wb_addr;
    } stage_out_t;

    // command side of the memory port
    typedef struct packed {
        logic        start;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] wmask;
    } mem_cmd_t;

    // pending register write, seen by the hazard unit
    typedef struct packed {
        logic       rf_wen;
        logic [4:0] wb_addr;
    } hazard_t;

    // ************************************************************
    // bubbles
    // ************************************************************

    // addi x0, x0, 0
    localparam logic [31:0] inst_nop = 32'h0000_0013;

    localparam stage_in_t bubble_in = '{
        pc: 32'h0, inst: inst_nop, alu_out: 32'h0, rs2_data: 32'h0,
        br_flg: 1'b0, br_target: 32'h0, jmp_flg: 1'b0, mem_op: mem_none,
        rf_wen: 1'b0, wb_sel: wb_none, wb_addr: 5'd0
    };

    localparam stage_out_t bubble_out = '{
        pc: 32'h0, inst: inst_nop, alu_out: 32'h0, read_data: 32'h0,
        br_flg: 1'b0, br_target: 32'h0, jmp_flg: 1'b0,
        rf_wen: 1'b0, wb_sel: wb_none, wb_addr: 5'd0
    };

endpackage

//--- logic/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top
    import mem_stage_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  stage_in_t   in_bundle,
    input  logic        flush,
    output logic        stall,
    output mem_cmd_t    mem_cmd,
    input  logic        cmd_ready,
    input  logic [31:0] rdata,
    input  logic        rdata_valid,
    output stage_out_t  out_bundle,
    output hazard_t     hazard
);

    stage_in_t   saved;
    logic        capture;
    logic        use_saved;
    logic        amo_write;
    logic        cmd_start;
    logic        cmd_write;
    logic        retire_current;
    logic        retire_saved;
    logic [31:0] load_data;

    // ************************************************************
    // control
    // ************************************************************
    mem_access_ctrl ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .cur_op         (in_bundle.mem_op),
        .saved_op       (saved.mem_op),
        .cmd_ready      (cmd_ready),
        .rdata_valid    (rdata_valid),
        .capture        (capture),
        .use_saved      (use_saved),
        .amo_write      (amo_write),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .retire_current (retire_current),
        .retire_saved   (retire_saved),
        .stall          (stall)
    );

    // ************************************************************
    // datapath
    // ************************************************************
    stage_hold_reg #(
        .payload_t  (stage_in_t),
        .bubble_val (bubble_in)
    ) hold_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .capture (capture),
        .flush   (flush),
        .d       (in_bundle),
        .q       (saved)
    );

    store_formatter fmt_i (
        .cur       (in_bundle),
        .saved     (saved),
        .use_saved (use_saved),
        .amo_write (amo_write),
        .cmd_start (cmd_start),
        .cmd_write (cmd_write),
        .cmd       (mem_cmd)
    );

    load_aligner align_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .op          (saved.mem_op),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .amo_write   (amo_write),
        .load_data   (load_data)
    );

    wb_output_reg wb_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .cur            (in_bundle),
        .saved          (saved),
        .use_saved      (use_saved),
        .retire_current (retire_current),
        .retire_saved   (retire_saved),
        .load_data      (load_data),
        .out_bundle     (out_bundle),
        .hazard         (hazard)
    );

endmodule

//--- logic/stage_hold_reg.sv
`timescale 1ns/1ps

module stage_hold_reg #(
    parameter type      payload_t  = logic [31:0],
    parameter payload_t bubble_val = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     capture,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // keeps the instruction stable while memory is busy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= bubble_val;
        end else if (flush) begin
            // squashed instruction leaves a bubble behind
            q <= bubble_val;
        end else if (capture) begin
            q <= d;
        end
    end

endmodule

//--- logic/store_formatter.sv
`timescale 1ns/1ps

module store_formatter
    import mem_stage_pkg::*;
(
    input  stage_in_t cur,
    input  stage_in_t saved,
    input  logic      use_saved,
    input  logic      amo_write,
    input  logic      cmd_start,
    input  logic      cmd_write,
    output mem_cmd_t  cmd
);

    stage_in_t   src;
    logic [31:0] byte_mask;

    assign src = use_saved ? saved : cur;

    // mask for the store width, the swap falls to the full word
    always_comb begin
        case (src.mem_op)
            mem_sb:  byte_mask = 32'h0000_00ff;
            mem_sh:  byte_mask = 32'h0000_ffff;
            default: byte_mask = 32'hffff_ffff;
        endcase
    end

    always_comb begin
        cmd.start = cmd_start;
        cmd.write = cmd_write;
        cmd.addr  = src.alu_out;
        cmd.wdata = src.rs2_data;
        cmd.wmask = byte_mask;
    end

endmodule

//--- logic/wb_output_reg.sv
`timescale 1ns/1ps

module wb_output_reg
    import mem_stage_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  stage_in_t   cur,
    input  stage_in_t   saved,
    input  logic        use_saved,
    input  logic        retire_current,
    input  logic        retire_saved,
    input  logic [31:0] load_data,
    output stage_out_t  out_bundle,
    output hazard_t     hazard
);

    stage_in_t  src;
    stage_out_t out_next;

    // drop the memory-only fields and insert the read data
    function automatic stage_out_t to_out(input stage_in_t b, input logic [31:0] rd);
        stage_out_t o;
        o.pc        = b.pc;
        o.inst      = b.inst;
        o.alu_out   = b.alu_out;
        o.read_data = rd;
        o.br_flg    = b.br_flg;
        o.br_target = b.br_target;
        o.jmp_flg   = b.jmp_flg;
        o.rf_wen    = b.rf_wen;
        o.wb_sel    = b.wb_sel;
        o.wb_addr   = b.wb_addr;
        return o;
    endfunction

    assign src = use_saved ? saved : cur;

    // stores and non-memory ops carry no read data
    always_comb begin
        if (retire_current) begin
            out_next = to_out(cur, 32'h0);
        end else if (retire_saved) begin
            out_next = to_out(saved, load_data);
        end else begin
            out_next = bubble_out;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_bundle <= bubble_out;
        end else begin
            out_bundle <= out_next;
        end
    end

    // destination of the instruction in the stage
    assign hazard.rf_wen  = src.rf_wen;
    assign hazard.wb_addr = src.wb_addr;

endmodule

//--- tests/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb
    import mem_stage_pkg::*;
();

    localparam int n_alu   = 40;
    localparam int n_store = 40;
    localparam int n_load  = 60;
    localparam int n_amo   = 12;
    localparam int n_flush = 20;
    localparam int n_mixed = 40;
    // each flush round adds drain bubbles and one follow-up instruction
    localparam int num_instr  = n_alu + n_store + n_load + 2 * n_amo + 7 * n_flush + n_mixed + 12;
    localparam int max_cycles = num_instr * 12;

    logic        clk = 1'b0;
    logic        rst_n;
    stage_in_t   in_bundle;
    logic        flush;
    logic        stall;
    mem_cmd_t    mem_cmd;
    logic        cmd_ready   = 1'b0;
    logic [31:0] rdata       = 32'h0;
    logic        rdata_valid = 1'b0;
    stage_out_t  out_bundle;
    hazard_t     hazard;

    // memory responder
    logic [31:0] mem_array [256];
    logic [31:0] resp_word;
    logic [31:0] resp_rand;
    logic [7:0]  resp_idx;
    logic [2:0]  resp_cnt  = 3'd0;
    logic [1:0]  ready_gap = 2'd0;

    // reference model
    logic [31:0] model_mem [256];
    stage_out_t  exp_out;
    integer      seed      = 69;
    integer      resp_seed = 69;
    int          cycle_count = 0;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          instr_count;
    int          test_err_start;
    int          test_instr_start;

    always #50 clk = ~clk;

    mem_stage_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_bundle   (in_bundle),
        .flush       (flush),
        .stall       (stall),
        .mem_cmd     (mem_cmd),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .out_bundle  (out_bundle),
        .hazard      (hazard)
    );

    // ************************************************************
    // helpers
    // ************************************************************

    // pattern over the whole word address
    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {a ^ 8'hc3, a + 8'h1f, ~a, {a[3:0], a[7:4]}};
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] store_mask(input mem_op_e op);
        case (op)
            mem_sb:  return 32'h0000_00ff;
            mem_sh:  return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic logic [31:0] extend_load(input mem_op_e op, input logic [31:0] w);
        case (op)
            mem_lb:  return {{24{w[7]}}, w[7:0]};
            mem_lbu: return {24'h0, w[7:0]};
            mem_lh:  return {{16{w[15]}}, w[15:0]};
            mem_lhu: return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic stage_out_t expect_out(input stage_in_t b, input logic [31:0] rd);
        stage_out_t o;
        o.pc        = b.pc;
        o.inst      = b.inst;
        o.alu_out   = b.alu_out;
        o.read_data = rd;
        o.br_flg    = b.br_flg;
        o.br_target = b.br_target;
        o.jmp_flg   = b.jmp_flg;
        o.rf_wen    = b.rf_wen;
        o.wb_sel    = b.wb_sel;
        o.wb_addr   = b.wb_addr;
        return o;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // memory ops stay inside the first 16 words so loads hit earlier stores
    task automatic make_bundle(input mem_op_e op, output stage_in_t b);
        logic [31:0] r;
        r           = rand_word();
        b.pc        = {r[31:2], 2'b00};
        b.inst      = rand_word();
        b.alu_out   = rand_word();
        if (op != mem_none) begin
            r         = rand_word();
            b.alu_out = {26'h0, r[3:0], 2'b00};
        end
        b.rs2_data  = rand_word();
        b.br_target = rand_word();
        r           = rand_word();
        b.br_flg    = r[0];
        b.jmp_flg   = r[1];
        b.rf_wen    = r[2];
        b.wb_sel    = wb_sel_e'(r[4:3]);
        b.wb_addr   = r[9:5];
        b.mem_op    = op;
    endtask

    task automatic rand_store_op(output mem_op_e op);
        logic [31:0] r;
        r = rand_word();
        case (r[1:0])
            2'd0:    op = mem_sb;
            2'd1:    op = mem_sh;
            default: op = mem_sw;
        endcase
    endtask

    task automatic rand_load_op(output mem_op_e op);
        logic [31:0] r;
        r = rand_word();
        case (r[2:0])
            3'd0:    op = mem_lb;
            3'd1:    op = mem_lh;
            3'd2:    op = mem_lbu;
            3'd3:    op = mem_lhu;
            default: op = mem_lw;
        endcase
    endtask

    task automatic rand_any_op(output mem_op_e op);
        logic [31:0] r;
        r  = rand_word();
        op = (r[3:0] > 4'd9) ? mem_op_e'(r[3:0] - 4'd6) : mem_op_e'(r[3:0]);
    endtask

    task automatic check_write_cmd(input mem_cmd_t c, input stage_in_t b,
                                   input logic [31:0] mask);
        if (c.write !== 1'b1) begin
            report_mismatch("store command without write flag");
        end
        if (c.addr !== b.alu_out) begin
            report_mismatch($sformatf("write addr %h, expected %h", c.addr, b.alu_out));
        end
        if (c.wdata !== b.rs2_data) begin
            report_mismatch($sformatf("wdata %h, expected %h", c.wdata, b.rs2_data));
        end
        if (c.wmask !== mask) begin
            report_mismatch($sformatf("wmask %h, expected %h", c.wmask, mask));
        end
    endtask

    task automatic check_read_cmd(input mem_cmd_t c, input stage_in_t b);
        if (c.write !== 1'b0) begin
            report_mismatch("read command with write flag set");
        end
        if (c.addr !== b.alu_out) begin
            report_mismatch($sformatf("read addr %h, expected %h", c.addr, b.alu_out));
        end
    endtask

    // ************************************************************
    // one instruction through the stage, checked every cycle
    // ************************************************************
    task automatic run_instr(input stage_in_t b, input bit do_flush);
        int          cyc;
        bit          done;
        bit          read_taken;
        bit          read_seen;
        bit          end_cond;
        bit          accepted;
        logic [31:0] rd_val;
        logic [31:0] old_word;
        logic [7:0]  idx;
        mem_cmd_t    c;
        in_bundle  <= b;
        flush      <= 1'b0;
        idx        = b.alu_out[9:2];
        cyc        = 0;
        done       = 1'b0;
        read_taken = 1'b0;
        read_seen  = 1'b0;
        rd_val     = 32'h0;
        old_word   = 32'h0;
        instr_count++;
        while (!done) begin
            @(posedge clk);
            c        = mem_cmd;
            accepted = c.start && cmd_ready;
            end_cond = 1'b0;
            if (out_bundle !== exp_out) begin
                report_mismatch($sformatf("out_bundle %h, expected %h", out_bundle, exp_out));
            end
            if (flush) begin
                if (c.start) begin
                    report_failure("memory command issued in the flush cycle");
                end
                exp_out = bubble_out;
                flush   <= 1'b0;
                done    = 1'b1;
            end else begin
                if (hazard.rf_wen !== b.rf_wen || hazard.wb_addr !== b.wb_addr) begin
                    report_mismatch($sformatf("hazard %b/%0d, expected %b/%0d",
                        hazard.rf_wen, hazard.wb_addr, b.rf_wen, b.wb_addr));
                end
                case (b.mem_op)
                    mem_sb, mem_sh, mem_sw: begin
                        if (accepted) begin
                            check_write_cmd(c, b, store_mask(b.mem_op));
                            model_mem[idx] = (model_mem[idx] & ~store_mask(b.mem_op))
                                           | (b.rs2_data & store_mask(b.mem_op));
                            end_cond = 1'b1;
                        end
                    end
                    mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu: begin
                        if (accepted) begin
                            if (read_taken) begin
                                report_failure("second read command for one load");
                            end
                            check_read_cmd(c, b);
                            read_taken = 1'b1;
                            old_word   = model_mem[idx];
                        end
                        if (rdata_valid) begin
                            rd_val   = extend_load(b.mem_op, old_word);
                            end_cond = 1'b1;
                        end
                    end
                    mem_amoswap: begin
                        if (accepted && !read_taken) begin
                            check_read_cmd(c, b);
                            read_taken = 1'b1;
                            old_word   = model_mem[idx];
                        end else if (accepted && read_seen) begin
                            check_write_cmd(c, b, 32'hffff_ffff);
                            model_mem[idx] = b.rs2_data;
                            rd_val         = old_word;
                            end_cond       = 1'b1;
                        end else if (accepted) begin
                            report_failure("swap issued a command while its read was pending");
                        end
                        if (rdata_valid && read_taken) begin
                            read_seen = 1'b1;
                        end
                    end
                    default: begin
                        if (c.start) begin
                            report_failure("memory command from a non-memory instruction");
                        end
                        end_cond = 1'b1;
                    end
                endcase
                if (stall !== !end_cond) begin
                    report_mismatch($sformatf("stall %b, expected %b", stall, !end_cond));
                end
                if (end_cond) begin
                    exp_out = expect_out(b, rd_val);
                    done    = 1'b1;
                end else begin
                    exp_out = bubble_out;
                    if (do_flush && cyc == 0) begin
                        flush <= 1'b1;
                    end
                end
            end
            cyc++;
        end
    endtask

    // bubbles until an abandoned read has been answered
    task automatic drain_responses();
        while (resp_cnt != 3'd0 || rdata_valid) begin
            run_instr(bubble_in, 1'b0);
        end
    endtask

    task automatic compare_memory();
        for (int i = 0; i < 256; i++) begin
            if (mem_array[i] !== model_mem[i]) begin
                report_mismatch($sformatf("memory word %0d is %h, model has %h",
                    i, mem_array[i], model_mem[i]));
            end
        end
    endtask

    task automatic begin_test();
        test_err_start   = errors;
        test_instr_start = instr_count;
    endtask

    task automatic end_test(input string name);
        int n_err;
        repeat (2) run_instr(bubble_in, 1'b0);
        compare_memory();
        n_err = errors - test_err_start;
        tests_run++;
        if (n_err != 0) begin
            tests_failed++;
        end
        $display("test %s: %0d instructions, %0d errors",
            name, instr_count - test_instr_start, n_err);
    endtask

    // ************************************************************
    // tests
    // ************************************************************
    task automatic test_reset_alu();
        stage_in_t b;
        begin_test();
        if (mem_cmd.start !== 1'b0) begin
            report_mismatch("mem_cmd.start high after reset");
        end
        if (out_bundle !== bubble_out) begin
            report_mismatch($sformatf("out_bundle %h after reset", out_bundle));
        end
        if (hazard.rf_wen !== 1'b0) begin
            report_mismatch("hazard rf_wen high after reset");
        end
        for (int i = 0; i < n_alu; i++) begin
            make_bundle(mem_none, b);
            run_instr(b, 1'b0);
        end
        end_test("reset_alu");
    endtask

    task automatic test_stores();
        stage_in_t b;
        mem_op_e   op;
        begin_test();
        for (int i = 0; i < n_store; i++) begin
            rand_store_op(op);
            make_bundle(op, b);
            run_instr(b, 1'b0);
        end
        end_test("stores");
    endtask

    task automatic test_loads();
        stage_in_t b;
        mem_op_e   op;
        begin_test();
        for (int i = 0; i < n_load; i++) begin
            rand_load_op(op);
            make_bundle(op, b);
            run_instr(b, 1'b0);
        end
        end_test("loads");
    endtask

    // swap, then read the same word back
    task automatic test_amoswap();
        stage_in_t b;
        stage_in_t rd;
        begin_test();
        for (int i = 0; i < n_amo; i++) begin
            make_bundle(mem_amoswap, b);
            run_instr(b, 1'b0);
            make_bundle(mem_lw, rd);
            rd.alu_out = b.alu_out;
            run_instr(rd, 1'b0);
        end
        end_test("amoswap");
    endtask

    task automatic test_flush();
        stage_in_t   b;
        mem_op_e     op;
        logic [31:0] r;
        begin_test();
        for (int i = 0; i < n_flush; i++) begin
            r = rand_word();
            if (r[0]) begin
                rand_load_op(op);
            end else begin
                rand_store_op(op);
            end
            make_bundle(op, b);
            run_instr(b, 1'b1);
            drain_responses();
            make_bundle(mem_none, b);
            run_instr(b, 1'b0);
        end
        end_test("flush");
    endtask

    task automatic test_mixed();
        stage_in_t b;
        mem_op_e   op;
        begin_test();
        for (int i = 0; i < n_mixed; i++) begin
            rand_any_op(op);
            make_bundle(op, b);
            run_instr(b, 1'b0);
        end
        end_test("hazard_mixed");
    endtask

    // ************************************************************
    // memory responder
    // ************************************************************
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                mem_array[i] <= fill_word(i[7:0]);
            end
            cmd_ready   <= 1'b0;
            rdata_valid <= 1'b0;
            rdata       <= 32'h0;
            resp_cnt    <= 3'd0;
            ready_gap   <= 2'd0;
        end else begin
            resp_rand = $random(resp_seed);
            resp_idx  = mem_cmd.addr[9:2];
            if (mem_cmd.start && cmd_ready) begin
                if (mem_cmd.write) begin
                    mem_array[resp_idx] <= (mem_array[resp_idx] & ~mem_cmd.wmask)
                                         | (mem_cmd.wdata & mem_cmd.wmask);
                end else begin
                    resp_word <= mem_array[resp_idx];
                    resp_cnt  <= 3'd1 + {1'b0, resp_rand[3:2]};
                end
                // ready drops for 0 to 3 cycles after each accepted command
                ready_gap <= resp_rand[1:0];
                cmd_ready <= (resp_rand[1:0] == 2'd0);
            end else if (ready_gap != 2'd0) begin
                ready_gap <= ready_gap - 2'd1;
                cmd_ready <= (ready_gap == 2'd1);
            end else begin
                cmd_ready <= 1'b1;
            end
            if (resp_cnt != 3'd0) begin
                resp_cnt <= resp_cnt - 3'd1;
            end
            if (resp_cnt == 3'd1) begin
                rdata_valid <= 1'b1;
                rdata       <= resp_word;
            end else begin
                rdata_valid <= 1'b0;
                rdata       <= 32'h0;
            end
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run still going after %0d cycles", max_cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        rst_n        = 1'b0;
        in_bundle    = bubble_in;
        flush        = 1'b0;
        exp_out      = bubble_out;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        instr_count  = 0;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = fill_word(i[7:0]);
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_reset_alu();
        test_stores();
        test_loads();
        test_amoswap();
        test_flush();
        test_mixed();
        $display("summary: %0d tests run, %0d with errors, %0d errors in total",
            tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
logic/mem_stage_pkg.sv
logic/mem_access_ctrl.sv
logic/stage_hold_reg.sv
logic/store_formatter.sv
logic/load_aligner.sv
logic/wb_output_reg.sv
logic/mem_stage_top.sv
tests/mem_stage_tb.sv
